//--- flow_pkg.sv
// Shared default widths, derived-width helpers and flit order for the serializer RTL; import it
package flow_pkg;

  // Default width of a wide flit on the push side
  parameter int default_push_width = 32;

  // Default width of a narrow flit on the pop side
  parameter int default_pop_width = 8;

  // Default sideband width, carried alongside every flit and never serialized
  parameter int default_metadata_width = 3;

  // Order in which the narrow slices of a wide flit leave the serializer
  typedef enum logic {lsb_first = 1'b0, msb_first = 1'b1} flit_order_e;

  // Number of narrow flits that make up one wide flit
  function automatic int ser_ratio(input int push_width, input int pop_width);
    return push_width / pop_width;
  endfunction

  // Width of a narrow flit index, never narrower than one bit
  function automatic int flit_id_width(input int push_width, input int pop_width);
    int ratio;
    ratio = ser_ratio(push_width, pop_width);
    return (ratio > 1) ? $clog2(ratio) : 1;
  endfunction

endpackage

//--- flow_reg_fwd.sv
// One-entry valid/ready register slice that cuts the forward path; instantiate with a payload type
module flow_reg_fwd #(
  // Any packed type, the slice only stores and forwards it
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  // Upstream side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,

  // Downstream side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_payload
);

  // Set while the slice holds an entry that has not yet left
  logic     full;
  payload_t entry;

  // Room is available when empty, or when the held entry leaves in this same cycle
  assign in_ready = !full || out_ready;

  // The stored entry is presented directly, so valid comes only from a flop
  assign out_valid   = full;
  assign out_payload = entry;

  // The full flag follows the upstream valid whenever the slice can take a new entry
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  // Payload is loaded only on an accepted transfer
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      entry <= in_payload;
    end
  end

  // A stalled entry must still be offered next cycle and must not change
  out_stable_a: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_payload)
  );

endmodule

//--- flow_serializer.sv
// Splits each wide push flit into narrow pop flits; combinational push to pop, counter-driven slicing
module flow_serializer import flow_pkg::*; #(
  // Wide flit width, a whole multiple of pop_width and larger than it
  parameter int push_width = default_push_width,
  // Narrow flit width
  parameter int pop_width = default_pop_width,
  // Sideband width, passed through beside every narrow flit
  parameter int metadata_width = default_metadata_width,
  // Which end of the wide flit is sent first
  parameter flit_order_e msb_first = flow_pkg::msb_first,
  localparam int ratio = ser_ratio(push_width, pop_width),
  localparam int id_width = flit_id_width(push_width, pop_width)
) (
  input  logic                      clk,
  input  logic                      rst,

  // Push side, one wide flit per transfer
  output logic                      push_ready,
  input  logic                      push_valid,
  input  logic [push_width-1:0]     push_data,
  input  logic                      push_last,
  input  logic [id_width-1:0]       push_last_dont_care_count,
  input  logic [metadata_width-1:0] push_metadata,

  // Pop side, one narrow flit per transfer
  input  logic                      pop_ready,
  output logic                      pop_valid,
  output logic [pop_width-1:0]      pop_data,
  output logic                      pop_last,
  output logic [metadata_width-1:0] pop_metadata
);

  // Index of the highest narrow flit in a full wide flit
  localparam logic [id_width-1:0] max_id = id_width'(ratio - 1);

  // Index of the narrow flit currently offered on the pop side
  logic [id_width-1:0] flit_id;

  // Index of the last narrow flit that carries real data
  logic [id_width-1:0] care_max;

  // Lane of push_data that the current index maps to
  logic [id_width-1:0] lane;

  logic final_flit;
  logic pop_xfer;

  // Trailing don't-care flits are simply never sent
  // The count is zero on a non-last flit, so care_max is then the highest index
  assign care_max   = max_id - push_last_dont_care_count;
  assign final_flit = (flit_id == care_max);
  assign pop_xfer   = pop_valid && pop_ready;

  // Each pop transfer moves to the next slice, and the final caring one wraps to 0
  always_ff @(posedge clk) begin
    if (rst) begin
      flit_id <= '0;
    end else if (pop_xfer) begin
      if (final_flit) begin
        flit_id <= '0;
      end else begin
        flit_id <= flit_id + 1'b1;
      end
    end
  end

  // Most-significant-first walks the lanes from the top down
  assign lane = (msb_first == flow_pkg::msb_first) ? max_id - flit_id : flit_id;

  // The wide flit is held on the push side until its final caring slice leaves,
  // so the pop side is a plain view into it
  assign pop_valid    = push_valid;
  assign pop_data     = push_data[lane*pop_width +: pop_width];
  assign pop_metadata = push_metadata;

  // Only the final caring slice of a last wide flit ends the packet
  assign pop_last = push_last && final_flit;

  // The wide flit is released in the same cycle its final caring slice is popped
  assign push_ready = pop_ready && final_flit;

  // The index never runs past the last caring slice of the flit being sent
  flit_id_range_a: assert property (
    @(posedge clk) disable iff (rst)
    push_valid |-> flit_id <= care_max
  );

endmodule

//--- flow_serializer_monitor.sv
// Protocol checker on the serializer push and pop ports; instantiate beside the serializer it watches
module flow_serializer_monitor import flow_pkg::*; #(
  parameter int push_width = default_push_width,
  parameter int pop_width = default_pop_width,
  parameter int metadata_width = default_metadata_width,
  parameter flit_order_e msb_first = flow_pkg::msb_first,
  localparam int ratio = ser_ratio(push_width, pop_width),
  localparam int id_width = flit_id_width(push_width, pop_width)
) (
  input logic                      clk,
  input logic                      rst,

  // Push side as seen at the serializer
  input logic                      push_ready,
  input logic                      push_valid,
  input logic [push_width-1:0]     push_data,
  input logic                      push_last,
  input logic [id_width-1:0]       push_last_dont_care_count,
  input logic [metadata_width-1:0] push_metadata,

  // Pop side as seen at the serializer
  input logic                      pop_ready,
  input logic                      pop_valid,
  input logic [pop_width-1:0]      pop_data,
  input logic                      pop_last,
  input logic [metadata_width-1:0] pop_metadata
);

  // Own copy of the narrow flit index, kept apart from the serializer's counter
  logic [id_width-1:0] mon_flit_id;
  logic [id_width-1:0] mon_care_max;

  assign mon_care_max = id_width'(ratio - 1) - push_last_dont_care_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      mon_flit_id <= '0;
    end else if (pop_valid && pop_ready) begin
      mon_flit_id <= (mon_flit_id == mon_care_max) ? '0 : mon_flit_id + 1'b1;
    end
  end

  default clocking mon_cb @(posedge clk);
  endclocking

  default disable iff (rst);

  // Input rules, which the upstream slice must honour
  push_stable_a: assert property (push_valid && !push_ready |=> push_valid &&
    $stable({push_data, push_last, push_last_dont_care_count, push_metadata}));
  dont_care_legal_a: assert property (
    push_valid && push_last |-> push_last_dont_care_count < ratio);
  dont_care_quiet_a: assert property (
    push_valid && !push_last |-> push_last_dont_care_count == '0);

  // Every index must show its own lane of the wide flit
  for (genvar i = 0; i < ratio; i++) begin : gen_lane
    localparam int lane = (msb_first == flow_pkg::msb_first) ? ratio - 1 - i : i;
    data_integrity_a: assert property (pop_valid && (mon_flit_id == i) |->
      pop_data == push_data[lane*pop_width +: pop_width]);
  end

  pop_valid_a: assert property (pop_valid == push_valid);
  metadata_a: assert property (pop_valid |-> pop_metadata == push_metadata);

  // The wide flit may only be released at its final caring slice
  push_ready_a: assert property (push_ready |-> mon_flit_id == mon_care_max);

  no_pop_last_a: assert property (
    push_valid && (!push_last || (mon_flit_id < mon_care_max)) |-> !pop_last);
  pop_last_a: assert property (
    push_valid && push_last && (mon_flit_id == mon_care_max) |-> pop_last);

  pop_stable_a: assert property (pop_valid && !pop_ready |=>
    $stable({pop_valid, pop_data, pop_last, pop_metadata}));

  // Both kinds of packet end should be seen
  dont_care_c: cover property (push_valid && push_last && push_last_dont_care_count != '0);
  full_last_c: cover property (push_valid && push_last && push_last_dont_care_count == '0);

endmodule

//--- flow_serializer_top.sv
// Registered width-reducing link: input slice, serializer with monitor, output slice; the DUT top
module flow_serializer_top import flow_pkg::*; #(
  parameter int push_width = default_push_width,
  parameter int pop_width = default_pop_width,
  parameter int metadata_width = default_metadata_width,
  parameter flit_order_e msb_first = flow_pkg::msb_first,
  localparam int id_width = flit_id_width(push_width, pop_width)
) (
  input  logic                      clk,
  input  logic                      rst,

  output logic                      push_ready,
  input  logic                      push_valid,
  input  logic [push_width-1:0]     push_data,
  input  logic                      push_last,
  input  logic [id_width-1:0]       push_last_dont_care_count,
  input  logic [metadata_width-1:0] push_metadata,

  input  logic                      pop_ready,
  output logic                      pop_valid,
  output logic [pop_width-1:0]      pop_data,
  output logic                      pop_last,
  output logic [metadata_width-1:0] pop_metadata
);

  // Wide flit as stored in the input slice
  typedef struct packed {
    logic [push_width-1:0]     data;
    logic                      last;
    logic [id_width-1:0]       dont_care_count;
    logic [metadata_width-1:0] metadata;
  } push_flit_t;

  // Narrow flit as stored in the output slice
  typedef struct packed {
    logic [pop_width-1:0]      data;
    logic                      last;
    logic [metadata_width-1:0] metadata;
  } pop_flit_t;

  // Between the input slice and the serializer
  logic                      ser_push_ready;
  logic                      ser_push_valid;
  logic [push_width-1:0]     ser_push_data;
  logic                      ser_push_last;
  logic [id_width-1:0]       ser_push_last_dont_care_count;
  logic [metadata_width-1:0] ser_push_metadata;

  // Between the serializer and the output slice
  logic                      ser_pop_ready;
  logic                      ser_pop_valid;
  logic [pop_width-1:0]      ser_pop_data;
  logic                      ser_pop_last;
  logic [metadata_width-1:0] ser_pop_metadata;

  // Concatenation order follows push_flit_t field order
  flow_reg_fwd #(.payload_t(push_flit_t)) u_push_reg (
    .clk, .rst,
    .in_valid(push_valid), .in_ready(push_ready),
    .in_payload({push_data, push_last, push_last_dont_care_count, push_metadata}),
    .out_valid(ser_push_valid), .out_ready(ser_push_ready),
    .out_payload({ser_push_data, ser_push_last, ser_push_last_dont_care_count,
                  ser_push_metadata})
  );

  flow_serializer #(
    .push_width(push_width), .pop_width(pop_width),
    .metadata_width(metadata_width), .msb_first(msb_first)
  ) u_ser (
    .clk, .rst,
    .push_ready(ser_push_ready), .push_valid(ser_push_valid), .push_data(ser_push_data),
    .push_last(ser_push_last), .push_last_dont_care_count(ser_push_last_dont_care_count),
    .push_metadata(ser_push_metadata),
    .pop_ready(ser_pop_ready), .pop_valid(ser_pop_valid), .pop_data(ser_pop_data),
    .pop_last(ser_pop_last), .pop_metadata(ser_pop_metadata)
  );

  // Checker only observes the serializer ports
  flow_serializer_monitor #(
    .push_width(push_width), .pop_width(pop_width),
    .metadata_width(metadata_width), .msb_first(msb_first)
  ) u_mon (
    .clk, .rst,
    .push_ready(ser_push_ready), .push_valid(ser_push_valid), .push_data(ser_push_data),
    .push_last(ser_push_last), .push_last_dont_care_count(ser_push_last_dont_care_count),
    .push_metadata(ser_push_metadata),
    .pop_ready(ser_pop_ready), .pop_valid(ser_pop_valid), .pop_data(ser_pop_data),
    .pop_last(ser_pop_last), .pop_metadata(ser_pop_metadata)
  );

  // Concatenation order follows pop_flit_t field order
  flow_reg_fwd #(.payload_t(pop_flit_t)) u_pop_reg (
    .clk, .rst,
    .in_valid(ser_pop_valid), .in_ready(ser_pop_ready),
    .in_payload({ser_pop_data, ser_pop_last, ser_pop_metadata}),
    .out_valid(pop_valid), .out_ready(pop_ready),
    .out_payload({pop_data, pop_last, pop_metadata})
  );

endmodule

//--- tb_flow_checker.sv
// Testbench checker; watches the DUT ports and compares narrow flits against accepted push flits
module tb_flow_checker #(
  parameter int push_width = 32,
  parameter int pop_width = 8,
  parameter int metadata_width = 3,
  parameter int id_width = 2,
  // Set when the top slice of a wide flit leaves first
  parameter bit msb_first = 1'b1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push_ready,
  input  logic                      push_valid,
  input  logic [push_width-1:0]     push_data,
  input  logic                      push_last,
  input  logic [id_width-1:0]       push_last_dont_care_count,
  input  logic [metadata_width-1:0] push_metadata,
  input  logic                      pop_ready,
  input  logic                      pop_valid,
  input  logic [pop_width-1:0]      pop_data,
  input  logic                      pop_last,
  input  logic [metadata_width-1:0] pop_metadata,
  output int                        value_errors,
  output int                        protocol_errors,
  output int                        pending,
  output int                        pop_count
);

  localparam int ratio = push_width / pop_width;

  // Expected narrow flits, oldest first, with the cycle of their push transfer
  logic [pop_width-1:0]      exp_data[$];
  logic                      exp_last[$];
  logic [metadata_width-1:0] exp_meta[$];
  int                        exp_cycle[$];

  // Pop side as seen at the previous edge, kept while it was stalled
  logic                      held_valid;
  logic [pop_width-1:0]      held_data;
  logic                      held_last;
  logic [metadata_width-1:0] held_meta;
  int                        cycle;

  // Push valid at the previous edge, and whether the pop side must refill at this edge
  logic                      prev_push_valid;
  logic                      refill_due;

  // Cut one wide flit into the narrow flits it should produce
  task automatic queue_slices(input logic [push_width-1:0] data, input logic last,
                              input logic [id_width-1:0] dc,
                              input logic [metadata_width-1:0] meta, input int at);
    int count;
    int lane;
    int k;
    count = last ? ratio - int'(dc) : ratio;
    for (k = 0; k < count; k++) begin
      lane = msb_first ? ratio - 1 - k : k;
      exp_data.push_back(data[lane*pop_width +: pop_width]);
      // Only the final caring slice of a last flit ends the packet
      exp_last.push_back(last && (k == count - 1));
      exp_meta.push_back(meta);
      exp_cycle.push_back(at);
    end
  endtask

  task automatic compare_pop();
    if (exp_data.size() == 0) begin
      $display("Extra narrow flit popped at cycle %0d with nothing expected", cycle);
      protocol_errors++;
    end else begin
      if (pop_data !== exp_data[0]) begin
        $display("FAILED pop_data expected 0x%h actual 0x%h", exp_data[0], pop_data);
        value_errors++;
      end
      if (pop_last !== exp_last[0]) begin
        $display("FAILED pop_last expected 0x%h actual 0x%h", exp_last[0], pop_last);
        value_errors++;
      end
      if (pop_metadata !== exp_meta[0]) begin
        $display("FAILED pop_metadata expected 0x%h actual 0x%h", exp_meta[0], pop_metadata);
        value_errors++;
      end
      void'(exp_data.pop_front());
      void'(exp_last.pop_front());
      void'(exp_meta.pop_front());
      void'(exp_cycle.pop_front());
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      exp_data.delete();
      exp_last.delete();
      exp_meta.delete();
      exp_cycle.delete();
      held_valid = 1'b0;
      prev_push_valid = 1'b0;
      refill_due = 1'b0;
      cycle = 0;
      value_errors = 0;
      protocol_errors = 0;
      pop_count = 0;
    end else begin
      cycle++;
      // A stalled narrow flit must be offered again unchanged
      if (held_valid && !pop_valid) begin
        $display("pop_valid dropped at cycle %0d while a flit was stalled", cycle);
        protocol_errors++;
      end else if (held_valid) begin
        if (pop_data !== held_data) begin
          $display("FAILED pop_data held 0x%h changed to 0x%h", held_data, pop_data);
          value_errors++;
        end
        if (pop_last !== held_last || pop_metadata !== held_meta) begin
          $display("FAILED pop_last/pop_metadata held 0x%h/0x%h changed to 0x%h/0x%h",
                   held_last, held_meta, pop_last, pop_metadata);
          value_errors++;
        end
      end
      // With a push flit waiting upstream, a popped narrow flit is replaced without a bubble
      if (refill_due && !pop_valid) begin
        $display("pop_valid dropped at cycle %0d though a push flit was waiting upstream",
                 cycle);
        protocol_errors++;
      end
      // Two cycles after its push, the oldest pending flit must be on the pop side
      if (!pop_valid && exp_cycle.size() > 0 && exp_cycle[0] <= cycle - 2) begin
        $display("pop_valid low at cycle %0d though a flit pushed at cycle %0d is pending",
                 cycle, exp_cycle[0]);
        protocol_errors++;
      end
      if (pop_valid && pop_ready) begin
        pop_count++;
        compare_pop();
      end
      if (push_valid && push_ready) begin
        queue_slices(push_data, push_last, push_last_dont_care_count, push_metadata, cycle);
      end
      refill_due = pop_valid && pop_ready && prev_push_valid;
      prev_push_valid = push_valid;
      held_valid = pop_valid && !pop_ready;
      held_data = pop_data;
      held_last = pop_last;
      held_meta = pop_metadata;
    end
    pending = exp_data.size();
  end

endmodule

//--- tb_flow_serializer.sv
// Testbench top for the serializer link; reads serializer_cases.txt, drives pushes and reports
module tb_flow_serializer;

  // Widths match the DUT defaults
  localparam int push_width = 32;
  localparam int pop_width = 8;
  localparam int metadata_width = 3;
  localparam int ratio = push_width / pop_width;
  localparam int id_width = (ratio > 1) ? $clog2(ratio) : 1;
  localparam int drive_delay = 5;
  // Cases in this index range are sent with pop_ready held high
  localparam int steady_first = 5;
  localparam int steady_last = 9;

  logic                      clk;
  logic                      rst;
  logic                      push_ready;
  logic                      push_valid;
  logic [push_width-1:0]     push_data;
  logic                      push_last;
  logic [id_width-1:0]       push_last_dont_care_count;
  logic [metadata_width-1:0] push_metadata;
  logic                      pop_ready;
  logic                      pop_valid;
  logic [pop_width-1:0]      pop_data;
  logic                      pop_last;
  logic [metadata_width-1:0] pop_metadata;

  // One entry per line of the case file
  logic [push_width-1:0]     case_data[$];
  logic                      case_last[$];
  logic [id_width-1:0]       case_dc[$];
  logic [metadata_width-1:0] case_meta[$];
  int                        case_gap[$];

  int num_cases;
  int expected_flits;
  int count_errors;
  int seed;
  bit cases_loaded;
  bit steady;

  // Results gathered by the checker
  int value_errors;
  int protocol_errors;
  int pending;
  int pop_count;

  flow_serializer_top dut0 (
    .clk(clk), .rst(rst),
    .push_ready(push_ready), .push_valid(push_valid), .push_data(push_data),
    .push_last(push_last), .push_last_dont_care_count(push_last_dont_care_count),
    .push_metadata(push_metadata),
    .pop_ready(pop_ready), .pop_valid(pop_valid), .pop_data(pop_data),
    .pop_last(pop_last), .pop_metadata(pop_metadata)
  );

  tb_flow_checker #(
    .push_width(push_width), .pop_width(pop_width),
    .metadata_width(metadata_width), .id_width(id_width), .msb_first(1'b1)
  ) chk0 (
    .clk(clk), .rst(rst),
    .push_ready(push_ready), .push_valid(push_valid), .push_data(push_data),
    .push_last(push_last), .push_last_dont_care_count(push_last_dont_care_count),
    .push_metadata(push_metadata),
    .pop_ready(pop_ready), .pop_valid(pop_valid), .pop_data(pop_data),
    .pop_last(pop_last), .pop_metadata(pop_metadata),
    .value_errors(value_errors), .protocol_errors(protocol_errors),
    .pending(pending), .pop_count(pop_count)
  );

  always #20 clk = ~clk;

  // Pop back-pressure, high about three quarters of the time outside the steady stretch
  always @(posedge clk) begin
    #drive_delay;
    pop_ready = steady ? 1'b1 : (($random(seed) & 3) != 0);
  end

  // Lines that do not parse as five fields are comments and are skipped
  task automatic read_cases(input int fd);
    logic [8*160-1:0]          line;
    logic [push_width-1:0]     data;
    logic                      last;
    logic [id_width-1:0]       dc;
    logic [metadata_width-1:0] meta;
    int                        gap;
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) != 0 &&
          $sscanf(line, "%h %h %h %h %d", data, last, dc, meta, gap) == 5) begin
        case_data.push_back(data);
        case_last.push_back(last);
        case_dc.push_back(dc);
        case_meta.push_back(meta);
        case_gap.push_back(gap);
        // A last flit drops its trailing don't-care slices
        expected_flits += last ? ratio - int'(dc) : ratio;
      end
    end
  endtask

  // The limit grows with the number of cases and allows slow back-pressure
  initial begin : watchdog
    int limit;
    wait (cases_loaded);
    limit = num_cases * ratio * 8 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT did not deliver every narrow flit", limit);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    int fd;
    int i;
    clk = 1'b0;
    rst = 1'b1;
    seed = 63;
    steady = 1'b0;
    pop_ready = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    push_last = 1'b0;
    push_last_dont_care_count = '0;
    push_metadata = '0;
    expected_flits = 0;
    count_errors = 0;
    fd = $fopen("serializer_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file serializer_cases.txt");
      $display("TEST FAIL");
      $finish;
    end else begin
      read_cases(fd);
      $fclose(fd);
      num_cases = case_data.size();
      cases_loaded = 1'b1;
      repeat (5) @(posedge clk);
      #drive_delay rst = 1'b0;
      @(posedge clk);
      for (i = 0; i < num_cases; i++) begin
        steady = (i >= steady_first) && (i <= steady_last);
        if (case_gap[i] > 0) begin
          #drive_delay push_valid = 1'b0;
          repeat (case_gap[i]) @(posedge clk);
        end
        #drive_delay;
        push_valid = 1'b1;
        push_data = case_data[i];
        push_last = case_last[i];
        push_last_dont_care_count = case_dc[i];
        push_metadata = case_meta[i];
        // Hold the flit until the input slice takes it
        do @(posedge clk); while (!push_ready);
      end
      steady = 1'b0;
      #drive_delay push_valid = 1'b0;
      // The checker updates on the rising edge, so its counts are read on the falling edge
      do @(negedge clk); while (pending != 0);
      repeat (10) @(negedge clk);
      if (pop_count != expected_flits) begin
        $display("Wrong number of narrow flits, expected %0d but saw %0d",
                 expected_flits, pop_count);
        count_errors++;
      end
      $display("Errors: %0d wrong values, %0d protocol, %0d flit count",
               value_errors, protocol_errors, count_errors);
      if (value_errors + protocol_errors + count_errors == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

//--- serializer_cases.txt
# data(hex) last dont_care(hex) metadata(hex) gap(decimal idle cycles before the flit)
# one wide push flit per line
11223344 0 0 1 3
a5b6c7d8 1 0 2 0
01234567 1 1 3 0
89abcdef 1 2 4 2
deadbeef 1 3 5 0
cafef00d 0 0 6 0
0f1e2d3c 0 0 7 0
4b5a6978 1 1 0 0
87968574 0 0 1 0
fedcba98 1 0 2 0
13579bdf 0 0 3 4
2468ace0 1 2 4 1
55aa33cc 0 0 5 0
00ff00ff 1 3 6 2

//--- flist.f
flow_pkg.sv
flow_reg_fwd.sv
flow_serializer.sv
flow_serializer_monitor.sv
flow_serializer_top.sv
tb_flow_checker.sv
tb_flow_serializer.sv
